// ==== design/core_pkg.sv ====
// shared widths, opcodes and instruction formats, imported by every core module
`default_nettype none

package core_pkg;

  localparam int xlen       = 64;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_trap  = 7'h6b;

  localparam logic [2:0] funct3_add   = 3'b000;
  localparam logic [2:0] funct3_ld_sd = 3'b011;
  localparam logic [6:0] funct7_sub   = 7'b0100000;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r_fmt;
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i_fmt;
    struct packed {
      logic [6:0]            imm_hi;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s_fmt;
  } inst_t;

  typedef enum logic [1:0] {
    add,
    sub,
    pass_b
  } alu_op_t;

endpackage

`default_nettype wire

// ==== design/fetch_stage.sv ====
// fetch stage that keeps the pc, reads words over the instruction bus and hands them to decode
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  output logic            if_rw_valid,
  input  logic            if_rw_ready,
  output logic [xlen-1:0] if_rw_addr,
  input  logic [ilen-1:0] if_r_data,
  output logic            if_to_id_valid,
  output logic [xlen-1:0] if_to_id_pc,
  output inst_t           if_to_id_inst,
  input  logic            id_allowin,
  input  logic            halt
);

  logic [xlen-1:0] pc;
  logic            fetch_done;

  // ask for a word only when there is room for it on arrival
  assign if_rw_valid = !halt && (!if_to_id_valid || id_allowin);
  assign if_rw_addr  = pc;
  assign fetch_done  = if_rw_valid && if_rw_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc             <= reset_pc;
      if_to_id_valid <= 1'b0;
    end else if (fetch_done) begin
      pc             <= pc + xlen'(4);
      if_to_id_valid <= 1'b1;
    end else if (id_allowin) begin
      if_to_id_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_done) begin
      if_to_id_pc   <= pc;
      if_to_id_inst <= if_r_data;
    end
  end

  // pending read stays requested with its address until the bus answers or the core halts
  a_addr_hold: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=>
      (if_rw_valid || halt) && if_rw_addr == $past(if_rw_addr));

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// decode stage: splits the instruction word, reads operands and stalls on register hazards
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  if_to_id_valid,
  input  logic [xlen-1:0]       if_to_id_pc,
  input  inst_t                 if_to_id_inst,
  output logic                  id_allowin,
  output logic                  id_to_ex_valid,
  output logic [xlen-1:0]       id_to_ex_pc,
  output logic [ilen-1:0]       id_to_ex_inst,
  output logic [reg_addr_w-1:0] id_to_ex_rd,
  output logic                  id_to_ex_wen,
  output alu_op_t               id_to_ex_alu_op,
  output logic                  id_to_ex_is_load,
  output logic                  id_to_ex_is_store,
  output logic [xlen-1:0]       id_to_ex_a,
  output logic [xlen-1:0]       id_to_ex_b,
  output logic [xlen-1:0]       id_to_ex_store_data,
  input  logic                  ex_allowin,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic [reg_addr_w-1:0] ex_busy_rd,
  input  logic                  ex_busy_valid,
  input  logic [reg_addr_w-1:0] mem_busy_rd,
  input  logic                  mem_busy_valid,
  input  logic [reg_addr_w-1:0] wb_busy_rd,
  input  logic                  wb_busy_valid
);

  logic [6:0]      opcode;
  logic            is_addi, is_add, is_sub, is_ld, is_sd;
  logic            use_rs1, use_rs2, rs1_busy, rs2_busy, hazard, out_free;
  logic [xlen-1:0] imm_i, imm_s;

  function automatic logic writes_src(input logic                  busy_valid,
                                      input logic [reg_addr_w-1:0] busy_rd,
                                      input logic [reg_addr_w-1:0] src);
    return busy_valid && busy_rd != '0 && busy_rd == src;
  endfunction

  assign opcode  = if_to_id_inst.r_fmt.opcode;
  assign is_addi = opcode == op_imm && if_to_id_inst.i_fmt.funct3 == funct3_add;
  assign is_add  = opcode == op_reg && if_to_id_inst.r_fmt.funct3 == funct3_add &&
                   if_to_id_inst.r_fmt.funct7 == '0;
  assign is_sub  = opcode == op_reg && if_to_id_inst.r_fmt.funct3 == funct3_add &&
                   if_to_id_inst.r_fmt.funct7 == funct7_sub;
  assign is_ld   = opcode == op_load && if_to_id_inst.i_fmt.funct3 == funct3_ld_sd;
  assign is_sd   = opcode == op_store && if_to_id_inst.s_fmt.funct3 == funct3_ld_sd;

  assign imm_i = {{(xlen-12){if_to_id_inst.i_fmt.imm[11]}}, if_to_id_inst.i_fmt.imm};
  assign imm_s = {{(xlen-12){if_to_id_inst.s_fmt.imm_hi[6]}},
                  if_to_id_inst.s_fmt.imm_hi, if_to_id_inst.s_fmt.imm_lo};

  // rs1/rs2 sit at the same bits in every format
  assign rs1_addr = if_to_id_inst.r_fmt.rs1;
  assign rs2_addr = if_to_id_inst.r_fmt.rs2;
  assign use_rs1  = is_addi || is_add || is_sub || is_ld || is_sd;
  assign use_rs2  = is_add || is_sub || is_sd;

  // no forwarding, so wait until older writers are out of the pipe
  assign rs1_busy = writes_src(ex_busy_valid, ex_busy_rd, rs1_addr) ||
                    writes_src(mem_busy_valid, mem_busy_rd, rs1_addr) ||
                    writes_src(wb_busy_valid, wb_busy_rd, rs1_addr);
  assign rs2_busy = writes_src(ex_busy_valid, ex_busy_rd, rs2_addr) ||
                    writes_src(mem_busy_valid, mem_busy_rd, rs2_addr) ||
                    writes_src(wb_busy_valid, wb_busy_rd, rs2_addr);
  assign hazard   = if_to_id_valid && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));

  assign out_free   = !id_to_ex_valid || ex_allowin;
  assign id_allowin = out_free && !hazard;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_to_ex_valid <= 1'b0;
    end else if (out_free) begin
      id_to_ex_valid <= if_to_id_valid && !hazard;
    end
  end

  always_ff @(posedge clock) begin
    if (if_to_id_valid && id_allowin) begin
      id_to_ex_pc         <= if_to_id_pc;
      id_to_ex_inst       <= if_to_id_inst;
      id_to_ex_rd         <= if_to_id_inst.r_fmt.rd;
      id_to_ex_wen        <= is_addi || is_add || is_sub || is_ld;
      id_to_ex_is_load    <= is_ld;
      id_to_ex_is_store   <= is_sd;
      id_to_ex_a          <= rs1_data;
      id_to_ex_b          <= (is_add || is_sub) ? rs2_data : (is_sd ? imm_s : imm_i);
      id_to_ex_store_data <= rs2_data;
      // unknown encodings just carry the immediate and write nothing
      id_to_ex_alu_op     <= is_sub ? sub : (use_rs1 ? add : pass_b);
    end
  end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
// execute stage: alu for arithmetic results and load/store addresses
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  id_to_ex_valid,
  input  logic [xlen-1:0]       id_to_ex_pc,
  input  logic [ilen-1:0]       id_to_ex_inst,
  input  logic [reg_addr_w-1:0] id_to_ex_rd,
  input  logic                  id_to_ex_wen,
  input  alu_op_t               id_to_ex_alu_op,
  input  logic                  id_to_ex_is_load,
  input  logic                  id_to_ex_is_store,
  input  logic [xlen-1:0]       id_to_ex_a,
  input  logic [xlen-1:0]       id_to_ex_b,
  input  logic [xlen-1:0]       id_to_ex_store_data,
  output logic                  ex_allowin,
  output logic                  ex_to_mem_valid,
  output logic [xlen-1:0]       ex_to_mem_pc,
  output logic [ilen-1:0]       ex_to_mem_inst,
  output logic [xlen-1:0]       ex_to_mem_result,
  output logic [reg_addr_w-1:0] ex_to_mem_rd,
  output logic                  ex_to_mem_wen,
  output logic                  ex_to_mem_is_load,
  output logic                  ex_to_mem_is_store,
  output logic [xlen-1:0]       ex_to_mem_store_data,
  input  logic                  mem_allowin,
  output logic [reg_addr_w-1:0] ex_busy_rd,
  output logic                  ex_busy_valid
);

  logic [xlen-1:0] alu_result;

  always_comb begin
    case (id_to_ex_alu_op)
      add:     alu_result = id_to_ex_a + id_to_ex_b;
      sub:     alu_result = id_to_ex_a - id_to_ex_b;
      default: alu_result = id_to_ex_b;
    endcase
  end

  assign ex_allowin    = !ex_to_mem_valid || mem_allowin;
  assign ex_busy_rd    = id_to_ex_rd;
  assign ex_busy_valid = id_to_ex_valid && id_to_ex_wen;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_to_mem_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_to_mem_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (id_to_ex_valid && ex_allowin) begin
      ex_to_mem_pc         <= id_to_ex_pc;
      ex_to_mem_inst       <= id_to_ex_inst;
      ex_to_mem_result     <= alu_result;
      ex_to_mem_rd         <= id_to_ex_rd;
      ex_to_mem_wen        <= id_to_ex_wen;
      ex_to_mem_is_load    <= id_to_ex_is_load;
      ex_to_mem_is_store   <= id_to_ex_is_store;
      ex_to_mem_store_data <= id_to_ex_store_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
// memory stage that runs ld/sd on the data bus and passes results to writeback
`timescale 1ns/1ps
`default_nettype none

module mem_stage import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ex_to_mem_valid,
  input  logic [xlen-1:0]       ex_to_mem_pc,
  input  logic [ilen-1:0]       ex_to_mem_inst,
  input  logic [xlen-1:0]       ex_to_mem_result,
  input  logic [reg_addr_w-1:0] ex_to_mem_rd,
  input  logic                  ex_to_mem_wen,
  input  logic                  ex_to_mem_is_load,
  input  logic                  ex_to_mem_is_store,
  input  logic [xlen-1:0]       ex_to_mem_store_data,
  output logic                  mem_allowin,
  output logic                  mem_to_wb_valid,
  output logic [xlen-1:0]       mem_to_wb_pc,
  output logic [ilen-1:0]       mem_to_wb_inst,
  output logic [xlen-1:0]       mem_to_wb_data,
  output logic [reg_addr_w-1:0] mem_to_wb_rd,
  output logic                  mem_to_wb_wen,
  input  logic                  wb_allowin,
  output logic                  mem_rw_valid,
  input  logic                  mem_rw_ready,
  output logic                  mem_rw_req,
  output logic [xlen-1:0]       mem_rw_addr,
  output logic [xlen-1:0]       mem_w_data,
  input  logic [xlen-1:0]       mem_r_data,
  output logic [reg_addr_w-1:0] mem_busy_rd,
  output logic                  mem_busy_valid
);

  logic mem_op, ready_go, out_free;

  assign mem_op   = ex_to_mem_is_load || ex_to_mem_is_store;
  // loads and stores stay here until the bus answers
  assign ready_go = !mem_op || mem_rw_ready;
  assign out_free = !mem_to_wb_valid || wb_allowin;

  assign mem_allowin  = out_free && ready_go;
  assign mem_rw_valid = ex_to_mem_valid && mem_op && out_free;
  assign mem_rw_req   = ex_to_mem_is_store;
  assign mem_rw_addr  = ex_to_mem_result;
  assign mem_w_data   = ex_to_mem_store_data;

  assign mem_busy_rd    = ex_to_mem_rd;
  assign mem_busy_valid = ex_to_mem_valid && ex_to_mem_wen;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_to_wb_valid <= 1'b0;
    end else if (out_free) begin
      mem_to_wb_valid <= ex_to_mem_valid && ready_go;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_to_mem_valid && mem_allowin) begin
      mem_to_wb_pc   <= ex_to_mem_pc;
      mem_to_wb_inst <= ex_to_mem_inst;
      mem_to_wb_data <= ex_to_mem_is_load ? mem_r_data : ex_to_mem_result;
      mem_to_wb_rd   <= ex_to_mem_rd;
      mem_to_wb_wen  <= ex_to_mem_wen;
    end
  end

  // bus requests only come from ld or sd words, direction matching the opcode
  a_mem_op_only: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid |-> ex_to_mem_inst[6:0] == (mem_rw_req ? op_store : op_load));

endmodule

`default_nettype wire

// ==== design/writeback_stage.sv ====
// writeback stage: register write, commit record, counters and trap detection
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  mem_to_wb_valid,
  input  logic [xlen-1:0]       mem_to_wb_pc,
  input  logic [ilen-1:0]       mem_to_wb_inst,
  input  logic [xlen-1:0]       mem_to_wb_data,
  input  logic [reg_addr_w-1:0] mem_to_wb_rd,
  input  logic                  mem_to_wb_wen,
  output logic                  wb_allowin,
  output logic                  reg_wr_ena,
  output logic [reg_addr_w-1:0] reg_wr_addr,
  output logic [xlen-1:0]       reg_wr_data,
  input  logic [xlen-1:0]       exit_code,
  output logic                  commit_valid,
  output logic [xlen-1:0]       commit_pc,
  output logic [ilen-1:0]       commit_inst,
  output logic                  commit_wen,
  output logic [reg_addr_w-1:0] commit_wdest,
  output logic [xlen-1:0]       commit_wdata,
  output logic                  trap_valid,
  output logic [7:0]            trap_code,
  output logic [xlen-1:0]       cycle_count,
  output logic [xlen-1:0]       instr_count,
  output logic                  halt,
  output logic [reg_addr_w-1:0] wb_busy_rd,
  output logic                  wb_busy_valid
);

  logic retire, is_trap;

  // anything still in flight behind the trap is dropped here
  assign retire  = mem_to_wb_valid && !halt;
  assign is_trap = retire && mem_to_wb_inst[6:0] == op_trap;

  assign wb_allowin    = 1'b1;
  assign reg_wr_ena    = retire && mem_to_wb_wen;
  assign reg_wr_addr   = mem_to_wb_rd;
  assign reg_wr_data   = mem_to_wb_data;
  assign wb_busy_rd    = mem_to_wb_rd;
  assign wb_busy_valid = mem_to_wb_valid && mem_to_wb_wen;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      trap_valid   <= 1'b0;
      halt         <= 1'b0;
      cycle_count  <= '0;
      instr_count  <= '0;
    end else begin
      commit_valid <= retire;
      trap_valid   <= is_trap;
      halt         <= halt || is_trap;
      cycle_count  <= cycle_count + xlen'(1);
      instr_count  <= instr_count + xlen'(retire);
    end
  end

  always_ff @(posedge clock) begin
    if (retire) begin
      commit_pc    <= mem_to_wb_pc;
      commit_inst  <= mem_to_wb_inst;
      commit_wen   <= mem_to_wb_wen;
      commit_wdest <= mem_to_wb_rd;
      commit_wdata <= mem_to_wb_data;
    end
    // a0 already holds the program's result when the trap gets here
    if (is_trap) begin
      trap_code <= exit_code[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
// integer register file, two combinational read ports with write-through and one write port
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  logic                  wr_ena,
  input  logic [reg_addr_w-1:0] wr_addr,
  input  logic [xlen-1:0]       wr_data,
  output logic [xlen-1:0]       exit_code
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr_ena && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr_ena && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

  // x10 is a0
  assign exit_code = regs[10];

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
// core top: five pipeline stages, register file, instruction and data bus ports
`timescale 1ns/1ps
`default_nettype none

module cpu_core import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  output logic                  if_rw_valid,
  input  logic                  if_rw_ready,
  output logic [xlen-1:0]       if_rw_addr,
  input  logic [ilen-1:0]       if_r_data,
  output logic                  mem_rw_valid,
  input  logic                  mem_rw_ready,
  output logic                  mem_rw_req,
  output logic [xlen-1:0]       mem_rw_addr,
  output logic [xlen-1:0]       mem_w_data,
  input  logic [xlen-1:0]       mem_r_data,
  output logic                  commit_valid,
  output logic [xlen-1:0]       commit_pc,
  output logic [ilen-1:0]       commit_inst,
  output logic                  commit_wen,
  output logic [reg_addr_w-1:0] commit_wdest,
  output logic [xlen-1:0]       commit_wdata,
  output logic                  trap_valid,
  output logic [7:0]            trap_code,
  output logic [xlen-1:0]       cycle_count,
  output logic [xlen-1:0]       instr_count
);

  // stage handshake
  logic if_to_id_valid, id_to_ex_valid, ex_to_mem_valid, mem_to_wb_valid;
  logic id_allowin, ex_allowin, mem_allowin, wb_allowin;
  logic [xlen-1:0] if_to_id_pc, id_to_ex_pc, ex_to_mem_pc, mem_to_wb_pc;
  inst_t           if_to_id_inst;
  logic [ilen-1:0] id_to_ex_inst, ex_to_mem_inst, mem_to_wb_inst;

  // stage payloads
  logic [reg_addr_w-1:0] id_to_ex_rd, ex_to_mem_rd, mem_to_wb_rd;
  logic                  id_to_ex_wen, ex_to_mem_wen, mem_to_wb_wen;
  alu_op_t               id_to_ex_alu_op;
  logic                  id_to_ex_is_load, id_to_ex_is_store;
  logic                  ex_to_mem_is_load, ex_to_mem_is_store;
  logic [xlen-1:0]       id_to_ex_a, id_to_ex_b, id_to_ex_store_data;
  logic [xlen-1:0]       ex_to_mem_result, ex_to_mem_store_data, mem_to_wb_data;

  // register file and hazard tracking
  logic [reg_addr_w-1:0] rs1_addr, rs2_addr, reg_wr_addr;
  logic [xlen-1:0]       rs1_data, rs2_data, reg_wr_data, exit_code;
  logic                  reg_wr_ena, halt;
  logic [reg_addr_w-1:0] ex_busy_rd, mem_busy_rd, wb_busy_rd;
  logic                  ex_busy_valid, mem_busy_valid, wb_busy_valid;

  fetch_stage fetch_stage_i (.*);

  decode_stage decode_stage_i (.*);

  execute_stage execute_stage_i (.*);

  mem_stage mem_stage_i (.*);

  writeback_stage writeback_stage_i (.*);

  regfile regfile_i (
    .wr_ena  (reg_wr_ena),
    .wr_addr (reg_wr_addr),
    .wr_data (reg_wr_data),
    .*
  );

endmodule

`default_nettype wire

// ==== tests/tb_bus_model.sv ====
// memory model for the testbench, serves the instruction and data buses with random ready delays
`timescale 1ns/1ps
`default_nettype none

module tb_bus_model import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            if_rw_valid,
  output logic            if_rw_ready,
  input  logic [xlen-1:0] if_rw_addr,
  output logic [ilen-1:0] if_r_data,
  input  logic            mem_rw_valid,
  output logic            mem_rw_ready,
  input  logic            mem_rw_req,
  input  logic [xlen-1:0] mem_rw_addr,
  input  logic [xlen-1:0] mem_w_data,
  output logic [xlen-1:0] mem_r_data
);

  localparam int              imem_words = 64;
  localparam int              dmem_words = 32;
  localparam logic [ilen-1:0] nop_word   = 32'h0000_0013;

  logic [ilen-1:0] imem [imem_words];
  logic [xlen-1:0] dmem [dmem_words];
  logic [1:0]      if_wait;
  logic [1:0]      mem_wait;
  integer          seed;

  task automatic load_inst(input int index, input logic [ilen-1:0] word);
    imem[index] = word;
  endtask

  // words past the loaded program read as nop
  function automatic logic [ilen-1:0] inst_at(input logic [xlen-1:0] addr);
    logic [xlen-1:0] offset;
    offset = addr - reset_pc;
    if (offset < xlen'(4 * imem_words)) begin
      return imem[offset[7:2]];
    end
    return nop_word;
  endfunction

  initial begin
    seed         = 18426;
    if_rw_ready  = 1'b0;
    if_r_data    = '0;
    mem_rw_ready = 1'b0;
    mem_r_data   = '0;
    if_wait      = 2'd0;
    mem_wait     = 2'd0;
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = nop_word;
    end
    // fill built from the byte address of each doubleword
    for (int i = 0; i < dmem_words; i++) begin
      dmem[i] = {32'(i * 8) ^ 32'h5a5a_5a5a, 32'(i * 8)};
    end
  end

  // both buses in one block so the random draws keep a fixed order
  always @(posedge clock) begin
    if (reset) begin
      if_rw_ready  <= 1'b0;
      mem_rw_ready <= 1'b0;
    end else begin
      if (if_rw_ready || !if_rw_valid) begin
        if_rw_ready <= 1'b0;
        if_wait     <= 2'($random(seed) & 3);
      end else if (if_wait == 2'd0) begin
        if_rw_ready <= 1'b1;
        if_r_data   <= inst_at(if_rw_addr);
      end else begin
        if_wait <= if_wait - 2'd1;
      end

      if (mem_rw_valid && mem_rw_ready && mem_rw_req) begin
        dmem[mem_rw_addr[7:3]] <= mem_w_data;
      end
      if (mem_rw_ready || !mem_rw_valid) begin
        mem_rw_ready <= 1'b0;
        mem_wait     <= 2'($random(seed) & 3);
      end else if (mem_wait == 2'd0) begin
        mem_rw_ready <= 1'b1;
        mem_r_data   <= dmem[mem_rw_addr[7:3]];
      end else begin
        mem_wait <= mem_wait - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_cpu_core.sv ====
// testbench for cpu_core that runs a short program from a table and checks commits, stores and trap
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import core_pkg::*; ();

  localparam int         num_rows       = 18;
  localparam int         clock_period   = 8;
  localparam int         reset_cycles   = 4;
  localparam int         idle_cycles    = 20;
  localparam int         timeout_cycles = reset_cycles + num_rows * 40 + idle_cycles;
  localparam logic [7:0] exit_value     = 8'h2a;

  logic                  clock, reset;
  logic                  if_rw_valid, if_rw_ready;
  logic [xlen-1:0]       if_rw_addr;
  logic [ilen-1:0]       if_r_data;
  logic                  mem_rw_valid, mem_rw_ready, mem_rw_req;
  logic [xlen-1:0]       mem_rw_addr, mem_w_data, mem_r_data;
  logic                  commit_valid, commit_wen, trap_valid;
  logic [xlen-1:0]       commit_pc, commit_wdata, cycle_count, instr_count;
  logic [ilen-1:0]       commit_inst;
  logic [reg_addr_w-1:0] commit_wdest;
  logic [7:0]            trap_code;
  time                   release_time;

  // program table with expected commit fields
  inst_t                 row_inst  [num_rows];
  logic [xlen-1:0]       row_pc    [num_rows];
  logic                  row_wen   [num_rows];
  logic [reg_addr_w-1:0] row_wdest [num_rows];
  logic [xlen-1:0]       row_wdata [num_rows];
  logic [xlen-1:0]       store_addr_q [$];
  logic [xlen-1:0]       store_data_q [$];

  cpu_core cpu_core_i (.*);

  tb_bus_model bus_model_i (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    $display("[FAIL] %0t ns: %s", $time, what);
    stop_run();
  endtask

  function automatic inst_t encode_i(input logic [6:0] opcode, input logic [2:0] funct3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    inst_t word;
    word.i_fmt.imm    = imm;
    word.i_fmt.rs1    = rs1;
    word.i_fmt.funct3 = funct3;
    word.i_fmt.rd     = rd;
    word.i_fmt.opcode = opcode;
    return word;
  endfunction

  function automatic inst_t encode_r(input logic [6:0] funct7, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
    inst_t word;
    word.r_fmt.funct7 = funct7;
    word.r_fmt.rs2    = rs2;
    word.r_fmt.rs1    = rs1;
    word.r_fmt.funct3 = funct3_add;
    word.r_fmt.rd     = rd;
    word.r_fmt.opcode = op_reg;
    return word;
  endfunction

  function automatic inst_t encode_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [11:0] imm);
    inst_t word;
    word.s_fmt.imm_hi = imm[11:5];
    word.s_fmt.rs2    = rs2;
    word.s_fmt.rs1    = rs1;
    word.s_fmt.funct3 = funct3_ld_sd;
    word.s_fmt.imm_lo = imm[4:0];
    word.s_fmt.opcode = op_store;
    return word;
  endfunction

  task automatic set_row(input int idx, input inst_t inst, input logic wen,
                         input logic [reg_addr_w-1:0] wdest, input logic [xlen-1:0] wdata);
    row_inst[idx]  = inst;
    row_pc[idx]    = reset_pc + xlen'(4 * idx);
    row_wen[idx]   = wen;
    row_wdest[idx] = wdest;
    row_wdata[idx] = wdata;
  endtask

  task automatic expect_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
    store_addr_q.push_back(addr);
    store_data_q.push_back(data);
  endtask

  task automatic check_commit(input int row, input inst_t exp_inst,
                              input logic [xlen-1:0] exp_pc, input logic exp_wen,
                              input logic [reg_addr_w-1:0] exp_wdest,
                              input logic [xlen-1:0] exp_wdata);
    if (commit_pc !== exp_pc)
      report_mismatch($sformatf("row %0d pc %h, expected %h", row, commit_pc, exp_pc));
    if (commit_inst !== exp_inst)
      report_mismatch($sformatf("row %0d inst %h, expected %h", row, commit_inst, exp_inst));
    if (commit_wen !== exp_wen)
      report_mismatch($sformatf("row %0d wen %b, expected %b", row, commit_wen, exp_wen));
    if (exp_wen && commit_wdest !== exp_wdest)
      report_mismatch($sformatf("row %0d wdest %0d, expected %0d", row, commit_wdest,
                                exp_wdest));
    // x0 as destination commits whatever the alu made
    if (exp_wen && exp_wdest != '0 && commit_wdata !== exp_wdata)
      report_mismatch($sformatf("row %0d wdata %h, expected %h", row, commit_wdata,
                                exp_wdata));
  endtask

  task automatic check_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
    logic [xlen-1:0] exp_addr;
    logic [xlen-1:0] exp_data;
    if (store_addr_q.size() == 0)
      report_mismatch($sformatf("store to %h with no store left in the program", addr));
    exp_addr = store_addr_q.pop_front();
    exp_data = store_data_q.pop_front();
    if (addr !== exp_addr || data !== exp_data)
      report_mismatch($sformatf("store %h <= %h, expected %h <= %h", addr, data,
                                exp_addr, exp_data));
  endtask

  task automatic check_trap(input logic [7:0] exp_code, input logic [xlen-1:0] exp_count);
    if (trap_valid !== 1'b1)
      report_mismatch("trap_valid low on the trap commit");
    if (trap_code !== exp_code)
      report_mismatch($sformatf("trap_code %h, expected %h", trap_code, exp_code));
    if (instr_count !== exp_count)
      report_mismatch($sformatf("instr_count %0d, expected %0d", instr_count, exp_count));
  endtask

  task automatic check_cycle_count(input logic [xlen-1:0] exp_cycles);
    if (cycle_count !== exp_cycles)
      report_mismatch($sformatf("cycle_count %0d, expected %0d", cycle_count, exp_cycles));
  endtask

  // every accepted write on the data bus
  always @(posedge clock) begin
    if (!reset && mem_rw_valid && mem_rw_ready && mem_rw_req) begin
      check_store(mem_rw_addr, mem_w_data);
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("timeout: program did not finish within %0d cycles", timeout_cycles);
    stop_run();
  end

  initial begin
    reset = 1'b1;
    // back-to-back dependents force decode stalls
    set_row(0, encode_i(op_imm, funct3_add, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 64'd5);
    set_row(1, encode_i(op_imm, funct3_add, 5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, -64'sd3);
    set_row(2, encode_r(7'd0, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 64'd2);
    set_row(3, encode_r(funct7_sub, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 64'd8);
    set_row(4, encode_r(funct7_sub, 5'd5, 5'd2, 5'd1), 1'b1, 5'd5, -64'sd8);
    set_row(5, encode_i(op_imm, funct3_add, 5'd6, 5'd3, 12'h7ff), 1'b1, 5'd6, 64'h801);
    set_row(6, encode_r(7'd0, 5'd7, 5'd6, 5'd6), 1'b1, 5'd7, 64'h1002);
    set_row(7, encode_i(op_imm, funct3_add, 5'd8, 5'd0, 12'h040), 1'b1, 5'd8, 64'h40);
    set_row(8, encode_s(5'd8, 5'd7, 12'd8), 1'b0, 5'd0, 64'd0);
    expect_store(64'h48, 64'h1002);
    set_row(9, encode_s(5'd8, 5'd5, 12'd16), 1'b0, 5'd0, 64'd0);
    expect_store(64'h50, -64'sd8);
    set_row(10, encode_i(op_load, funct3_ld_sd, 5'd9, 5'd8, 12'd8), 1'b1, 5'd9, 64'h1002);
    set_row(11, encode_i(op_load, funct3_ld_sd, 5'd11, 5'd8, 12'd16), 1'b1, 5'd11, -64'sd8);
    // never written, so the fill pattern comes back
    set_row(12, encode_i(op_load, funct3_ld_sd, 5'd12, 5'd8, 12'd24), 1'b1, 5'd12,
            64'h5a5a_5a02_0000_0058);
    set_row(13, encode_i(op_imm, funct3_add, 5'd0, 5'd1, 12'd100), 1'b1, 5'd0, 64'd0);
    set_row(14, encode_r(7'd0, 5'd13, 5'd0, 5'd1), 1'b1, 5'd13, 64'd5);
    // andi is outside the subset and retires as a no-op
    set_row(15, encode_i(op_imm, 3'b111, 5'd0, 5'd0, 12'd0), 1'b0, 5'd0, 64'd0);
    set_row(16, encode_i(op_imm, funct3_add, 5'd10, 5'd13, 12'd37), 1'b1, 5'd10,
            64'(exit_value));
    set_row(17, encode_i(op_trap, 3'b000, 5'd0, 5'd0, 12'd0), 1'b0, 5'd0, 64'd0);

    @(posedge clock);
    for (int i = 0; i < num_rows; i++) begin
      bus_model_i.load_inst(i, row_inst[i]);
    end
    repeat (reset_cycles - 1) @(posedge clock);
    release_time = $time;
    reset <= 1'b0;

    for (int i = 0; i < num_rows; i++) begin
      @(posedge clock);
      while (!commit_valid) @(posedge clock);
      check_commit(i, row_inst[i], row_pc[i], row_wen[i], row_wdest[i], row_wdata[i]);
      if (i < num_rows - 1 && trap_valid)
        report_mismatch($sformatf("trap_valid raised at row %0d", i));
    end
    check_trap(exit_value, xlen'(num_rows));
    // one count per edge since reset dropped, seen here one edge late
    check_cycle_count(xlen'(($time - release_time) / clock_period - 1));

    repeat (idle_cycles) begin
      @(posedge clock);
      if (commit_valid || trap_valid) begin
        $display("core kept committing after the trap");
        stop_run();
      end
    end
    if (store_addr_q.size() != 0) begin
      $display("%0d expected stores never reached the data bus", store_addr_q.size());
      stop_run();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
design/core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/writeback_stage.sv
design/regfile.sv
design/cpu_core.sv
tests/tb_bus_model.sv
tests/tb_cpu_core.sv
